// File: tb.f
common/l1_pkg.sv
logic/sram_dp.sv
lru/l1_lrum.sv
tag/l1_tag_array.sv
logic/l1_dir_top.sv
tb/l1_dir_props.sv
tb/l1_dir_checker.sv
tb/tb_top.sv

// File: Makefile
# Verilator flow for the L1 tag directory

VERILATOR  ?= verilator
TOP        ?= tb_top
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Simulation failed
PASS_MSG   ?= Simulation passed
VFLAGS     ?= --timing --assert -Wno-fatal
SIM_ARGS   ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BIN)
	-./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run incomplete, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_top.sv
// L1 directory testbench top
// Clock, reset, seeded random lookups and the watchdog
// Results are checked in l1_dir_checker, assertions come in through bind

module tb_top;

  import l1_pkg::*;

  localparam int WAY_NUM    = WAY_NUM_DEF;
  localparam int SET_NUM    = SET_NUM_DEF;
  localparam int TAG_WIDTH  = TAG_WIDTH_DEF;
  localparam int IDX_W      = $clog2(SET_NUM);
  localparam int CLK_PERIOD = 100;

  // Requests per test
  localparam int COLD_LEN   = SET_NUM * WAY_NUM;
  localparam int HIT_LEN    = 96;
  localparam int EVICT_LEN  = 96;
  localparam int B2B_LEN    = 128;
  localparam int LEN_SUM    = COLD_LEN + HIT_LEN + EVICT_LEN + B2B_LEN;
  localparam int WATCHDOG   = (LEN_SUM + SET_NUM) * CLK_PERIOD * 2;

  // Tag pool, first WAY_NUM entries fill every set
  localparam int POOL_EXTRA = 4;
  localparam int EVICT_SETS = (SET_NUM >= 4) ? 4 : SET_NUM;
  localparam int DONE_ID    = 5;

  logic                 clk;
  logic                 rst_n;
  logic                 req;
  logic [IDX_W-1:0]     idx;
  logic [TAG_WIDTH-1:0] tag;
  logic                 ready;
  logic                 hit;
  logic                 evict_val;
  logic [WAY_NUM-1:0]   way_vect;
  logic [TAG_WIDTH-1:0] evict_tag;

  int                   test_id;
  logic                 report_done;
  int                   err_total;
  int                   assert_fails;
  int unsigned          seed;
  int unsigned          tag_base;

  l1_dir_top #(
    .WAY_NUM   (WAY_NUM),
    .SET_NUM   (SET_NUM),
    .TAG_WIDTH (TAG_WIDTH)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .idx       (idx),
    .tag       (tag),
    .ready     (ready),
    .hit       (hit),
    .evict_val (evict_val),
    .way_vect  (way_vect),
    .evict_tag (evict_tag)
  );

  l1_dir_checker #(
    .WAY_NUM   (WAY_NUM),
    .SET_NUM   (SET_NUM),
    .TAG_WIDTH (TAG_WIDTH)
  ) u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .idx         (idx),
    .tag         (tag),
    .ready       (ready),
    .hit         (hit),
    .evict_val   (evict_val),
    .way_vect    (way_vect),
    .evict_tag   (evict_tag),
    .test_id     (test_id),
    .report_done (report_done),
    .err_total   (err_total)
  );

  bind l1_dir_top l1_dir_props #(
    .WAY_NUM   (WAY_NUM),
    .TAG_WIDTH (TAG_WIDTH)
  ) u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .tag       (tag),
    .ready     (ready),
    .hit       (hit),
    .evict_val (evict_val),
    .way_vect  (way_vect),
    .evict_tag (evict_tag)
  );

  // ------------------------------
  // Clock and watchdog
  // ------------------------------

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG);
    $display("Timeout after %0d time units, the tests did not finish", WATCHDOG);
    $display("Simulation failed");
    $finish;
  end

  // ------------------------------
  // Stimulus helpers
  // ------------------------------

  // Pool entry k, spaced so every entry differs
  function automatic logic [TAG_WIDTH-1:0] pool_tag(input int k);
    pool_tag = TAG_WIDTH'(tag_base + 32'(k) * 7);
  endfunction

  task automatic send_req(input int s, input int k);
    @(negedge clk);
    req = 1'b1;
    idx = IDX_W'(s);
    tag = pool_tag(k);
  endtask

  task automatic idle_cycle;
    @(negedge clk);
    req = 1'b0;
  endtask

  // Idle about one cycle in four
  task automatic random_gap;
    if ($urandom % 4 == 0) begin
      idle_cycle();
    end
  endtask

  // Let the last result drain, then move the checker on
  task automatic close_test(input int next_id);
    idle_cycle();
    repeat (3) @(negedge clk);
    test_id = next_id;
  endtask

  // ------------------------------
  // Tests
  // ------------------------------

  // Every set gets the first WAY_NUM pool tags in a rotated order
  task automatic cold_fills;
    int rot;
    for (int s = 0; s < SET_NUM; s++) begin
      rot = int'($urandom % WAY_NUM);
      for (int w = 0; w < WAY_NUM; w++) begin
        send_req(s, (w + rot) % WAY_NUM);
        random_gap();
      end
    end
  endtask

  // Only tags that the cold fills left behind
  task automatic repeat_hits;
    repeat (HIT_LEN) begin
      send_req(int'($urandom % SET_NUM), int'($urandom % WAY_NUM));
      random_gap();
    end
  endtask

  // New tags on a few full sets
  task automatic evictions;
    repeat (EVICT_LEN) begin
      send_req(int'($urandom % EVICT_SETS), WAY_NUM + int'($urandom % POOL_EXTRA));
    end
  endtask

  // No gaps, the set mostly repeats
  task automatic back_to_back;
    int s;
    s = int'($urandom % SET_NUM);
    repeat (B2B_LEN) begin
      if ($urandom % 4 == 0) begin
        s = int'($urandom % SET_NUM);
      end
      send_req(s, int'($urandom % (WAY_NUM + 2)));
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    seed     = $urandom(32'h4262);
    tag_base = $urandom;
    req      = 1'b0;
    idx      = '0;
    tag      = '0;
    rst_n    = 1'b0;
    test_id  = 0;

    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    // Watchdog bounds the wait for the clean
    while (!ready) @(negedge clk);
    close_test(1);

    cold_fills();
    close_test(2);
    repeat_hits();
    close_test(3);
    evictions();
    close_test(4);
    back_to_back();
    close_test(DONE_ID);

    while (!report_done) @(negedge clk);
    assert_fails = UUT.u_props.fail_count;
    if (err_total == 0 && assert_fails == 0) begin
      $display("Simulation passed");
    end else begin
      if (assert_fails != 0) begin
        $display("Assertion failures: %0d", assert_fails);
      end
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tb/l1_dir_checker.sv
// L1 directory checker
// Reference model of valid bits, tags and used bits per set
// Compares every result one cycle after its request, reports per test

module l1_dir_checker #(
  parameter int WAY_NUM   = 4,
  parameter int SET_NUM   = 16,
  parameter int TAG_WIDTH = 8
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req,
  input  logic [$clog2(SET_NUM)-1:0] idx,
  input  logic [TAG_WIDTH-1:0]       tag,
  input  logic                       ready,
  input  logic                       hit,
  input  logic                       evict_val,
  input  logic [WAY_NUM-1:0]         way_vect,
  input  logic [TAG_WIDTH-1:0]       evict_tag,
  // Test sequencing from the top
  input  int                         test_id,
  output logic                       report_done,
  output int                         err_total
);

  localparam int IDX_W     = $clog2(SET_NUM);
  localparam int LAST_TEST = 4;

  // Model state
  logic [WAY_NUM-1:0]   val_m  [SET_NUM];
  logic [TAG_WIDTH-1:0] tag_m  [SET_NUM][WAY_NUM];
  logic [WAY_NUM-1:0]   used_m [SET_NUM];

  // Request in flight and its expected result
  logic                 pend;
  logic [IDX_W-1:0]     pend_idx;
  logic                 exp_hit;
  logic                 exp_evict;
  logic [WAY_NUM-1:0]   exp_way;
  logic [TAG_WIDTH-1:0] exp_etag;

  int                   clean_cycles;
  logic                 ready_up;
  int                   last_id;
  int                   test_reqs;
  int                   test_errs;
  int                   req_total;
  int                   tests_run;

  initial begin
    report_done = 1'b0;
    err_total   = 0;
    last_id     = 0;
    test_reqs   = 0;
    test_errs   = 0;
    req_total   = 0;
    tests_run   = 0;
    pend        = 1'b0;
    pend_idx    = '0;
  end

  function automatic string test_name(input int id);
    case (id)
      0:       test_name = "reset_clean";
      1:       test_name = "cold_fills";
      2:       test_name = "hits";
      3:       test_name = "evictions";
      4:       test_name = "back_to_back";
      default: test_name = "unknown";
    endcase
  endfunction

  task automatic compare_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("Error: %s expected 0x%0h actual 0x%0h (test %0d, set 0x%0h)",
               name, exp_v, act_v, last_id, pend_idx);
      test_errs++;
      err_total++;
    end
  endtask

  task automatic clear_model;
    for (int s = 0; s < SET_NUM; s++) begin
      val_m[s]  = '0;
      used_m[s] = '0;
      for (int w = 0; w < WAY_NUM; w++) begin
        tag_m[s][w] = '0;
      end
    end
  endtask

  // ------------------------------
  // Lookup model
  // ------------------------------

  task automatic lookup_model(input logic [IDX_W-1:0] s, input logic [TAG_WIDTH-1:0] t);
    int   way;
    logic found;
    found = 1'b0;
    way   = 0;
    // Hit on a valid way with an equal tag
    for (int w = 0; w < WAY_NUM; w++) begin
      if (!found && val_m[s][w] && tag_m[s][w] == t) begin
        found = 1'b1;
        way   = w;
      end
    end
    exp_hit   = found;
    exp_evict = 1'b0;
    exp_etag  = t;
    if (!found) begin
      // Lowest way whose used bit is clear
      for (int w = WAY_NUM - 1; w >= 0; w--) begin
        if (!used_m[s][w]) begin
          way = w;
        end
      end
      exp_evict     = &val_m[s];
      exp_etag      = tag_m[s][way];
      tag_m[s][way] = t;
      val_m[s][way] = 1'b1;
    end
    exp_way      = '0;
    exp_way[way] = 1'b1;
    // Mark used, a full vector keeps only this way
    used_m[s][way] = 1'b1;
    if (&used_m[s]) begin
      used_m[s] = exp_way;
    end
  endtask

  // ------------------------------
  // Per-cycle checks
  // ------------------------------

  task automatic check_ready;
    if (!ready_up) begin
      if (ready) begin
        ready_up = 1'b1;
        compare_field("ready_low_cycles", 32'(SET_NUM), 32'(clean_cycles));
      end else begin
        clean_cycles++;
      end
    end else if (!ready) begin
      $display("ready fell low again after the clean had finished");
      test_errs++;
      err_total++;
    end
  endtask

  task automatic check_result;
    if (pend) begin
      compare_field("hit", 32'(exp_hit), 32'(hit));
      compare_field("way_vect", 32'(exp_way), 32'(way_vect));
      compare_field("evict_val", 32'(exp_evict), 32'(evict_val));
      if (exp_evict) begin
        compare_field("evict_tag", 32'(exp_etag), 32'(evict_tag));
      end
    end else begin
      // Quiet cycle
      compare_field("hit", 32'h0, 32'(hit));
      compare_field("evict_val", 32'h0, 32'(evict_val));
    end
  endtask

  task automatic report_test;
    $display("Test %0d %s: %0d requests, %0d errors",
             last_id, test_name(last_id), test_reqs, test_errs);
    tests_run++;
    req_total += test_reqs;
    test_reqs = 0;
    test_errs = 0;
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      clear_model();
      pend         = 1'b0;
      clean_cycles = 0;
      ready_up     = 1'b0;
      compare_field("hit", 32'h0, 32'(hit));
      compare_field("evict_val", 32'h0, 32'(evict_val));
    end else begin
      check_ready();
      check_result();
      pend = req;
      if (req) begin
        if (!ready) begin
          $display("A request arrived while ready was still low");
          test_errs++;
          err_total++;
        end
        pend_idx = idx;
        lookup_model(idx, tag);
        test_reqs++;
      end
      // Test boundary
      if (test_id != last_id) begin
        report_test();
        last_id = test_id;
        if (test_id > LAST_TEST) begin
          $display("Tests %0d, requests %0d, errors %0d", tests_run, req_total, err_total);
          report_done = 1'b1;
        end
      end
    end
  end

endmodule

// File: tb/l1_dir_props.sv
// L1 directory assertions
// Bound into the directory top level

module l1_dir_props #(
  parameter int WAY_NUM   = 4,
  parameter int TAG_WIDTH = 8
) (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 req,
  input logic [TAG_WIDTH-1:0] tag,
  input logic                 ready,
  input logic                 hit,
  input logic                 evict_val,
  input logic [WAY_NUM-1:0]   way_vect,
  input logic [TAG_WIDTH-1:0] evict_tag
);

  // Failures seen, read by the testbench at the end
  int fail_count = 0;

  // Result way in the analyze cycle
  way_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    req |=> $onehot(way_vect))
    else begin
      $error("way_vect is not one-hot one cycle after req");
      fail_count = fail_count + 1;
    end

  // Eviction only on a miss
  // Victim never holds the looked-up tag
  evict_on_miss: assert property (@(posedge clk) disable iff (!rst_n)
    evict_val |-> !hit && (evict_tag != $past(tag)))
    else begin
      $error("evict_val came with hit high or with the lookup tag as victim");
      fail_count = fail_count + 1;
    end

  // Clean happens once per reset
  ready_holds: assert property (@(posedge clk) disable iff (!rst_n)
    ready |=> ready)
    else begin
      $error("ready fell after it had risen");
      fail_count = fail_count + 1;
    end

endmodule

// File: logic/l1_dir_top.sv
// L1 tag directory top level
// Joins the tag array and the replacement state
// Results come one cycle after req

module l1_dir_top #(
  parameter int WAY_NUM   = l1_pkg::WAY_NUM_DEF,
  parameter int SET_NUM   = l1_pkg::SET_NUM_DEF,
  parameter int TAG_WIDTH = l1_pkg::TAG_WIDTH_DEF
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // Lookup request
  input  logic                       req,
  input  logic [$clog2(SET_NUM)-1:0] idx,
  input  logic [TAG_WIDTH-1:0]       tag,
  output logic                       ready,
  // Lookup result
  output logic                       hit,
  output logic                       evict_val,
  output logic [WAY_NUM-1:0]         way_vect,
  output logic [TAG_WIDTH-1:0]       evict_tag
);

  // Between the two arrays
  logic               lru_ready;
  logic               tag_ready;
  logic [WAY_NUM-1:0] ld_val_vect;
  logic [WAY_NUM-1:0] tag_cmp_vect;

  // Both arrays must be clean
  assign ready = lru_ready & tag_ready;

  l1_lrum #(
    .WAY_NUM   (WAY_NUM),
    .SET_NUM   (SET_NUM),
    .TAG_WIDTH (TAG_WIDTH)
  ) u_lrum (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .idx          (idx),
    .ready        (lru_ready),
    .ld_val_vect  (ld_val_vect),
    .tag_cmp_vect (tag_cmp_vect),
    .hit          (hit),
    .evict_val    (evict_val),
    .way_vect     (way_vect)
  );

  l1_tag_array #(
    .WAY_NUM   (WAY_NUM),
    .SET_NUM   (SET_NUM),
    .TAG_WIDTH (TAG_WIDTH)
  ) u_tag_array (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .idx          (idx),
    .tag          (tag),
    .hit          (hit),
    .way_vect     (way_vect),
    .ready        (tag_ready),
    .ld_val_vect  (ld_val_vect),
    .tag_cmp_vect (tag_cmp_vect),
    .evict_tag    (evict_tag)
  );

endmodule

// File: tag/l1_tag_array.sv
// L1 tag storage
// Valid bit and tag per way, one RAM word per set
// Self-clean, same-set bypass, compare vectors, fill and victim tag

module l1_tag_array #(
  parameter int WAY_NUM   = 4,
  parameter int SET_NUM   = 16,
  parameter int TAG_WIDTH = 8
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // Read stage
  input  logic                       req,
  input  logic [$clog2(SET_NUM)-1:0] idx,
  input  logic [TAG_WIDTH-1:0]       tag,
  // Analyze stage, from the replacement block
  input  logic                       hit,
  input  logic [WAY_NUM-1:0]         way_vect,
  output logic                       ready,
  output logic [WAY_NUM-1:0]         ld_val_vect,
  output logic [WAY_NUM-1:0]         tag_cmp_vect,
  output logic [TAG_WIDTH-1:0]       evict_tag
);

  import l1_pkg::*;

  localparam int IDX_W  = $clog2(SET_NUM);
  // Word layout is {tags, valid bits}
  localparam int WORD_W = WAY_NUM * (TAG_WIDTH + 1);

  clean_state_e                       clean_state_r;
  logic [IDX_W-1:0]                   clean_addr_r;
  logic                               clean_run;

  logic                               req_r;
  logic [IDX_W-1:0]                   idx_r;
  logic [TAG_WIDTH-1:0]               tag_r;
  logic                               bypass_r;
  logic [WORD_W-1:0]                  byp_word_r;

  logic [WORD_W-1:0]                  word_sram;
  logic [WORD_W-1:0]                  set_word;
  logic [WAY_NUM-1:0][TAG_WIDTH-1:0]  set_tags;
  logic [WAY_NUM-1:0][TAG_WIDTH-1:0]  fill_tags;
  logic [WAY_NUM-1:0]                 fill_val;
  logic [WORD_W-1:0]                  word_next;

  // ------------------------------
  // Hardware clean
  // ------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clean_state_r <= CLEAN_RUN;
      clean_addr_r  <= '0;
    end else if (clean_state_r == CLEAN_RUN) begin
      clean_addr_r <= clean_addr_r + 1'b1;
      if (clean_addr_r == IDX_W'(SET_NUM - 1)) begin
        clean_state_r <= CLEAN_DONE;
      end
    end
  end

  assign clean_run = (clean_state_r == CLEAN_RUN);
  assign ready     = ~clean_run;

  // ------------------------------
  // Read stage
  // ------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_r    <= 1'b0;
      bypass_r <= 1'b0;
    end else begin
      req_r    <= req;
      bypass_r <= req & req_r & (idx == idx_r);
    end
  end

  // Lookup payload, held for the analyze cycle
  always_ff @(posedge clk) begin
    if (req) begin
      idx_r <= idx;
      tag_r <= tag;
    end
  end

  // Set contents after the analyze update
  always_ff @(posedge clk) begin
    if (req_r) begin
      byp_word_r <= word_next;
    end
  end

  // ------------------------------
  // Analyze stage
  // ------------------------------

  assign set_word    = bypass_r ? byp_word_r : word_sram;
  assign ld_val_vect = set_word[WAY_NUM-1:0];
  assign set_tags    = set_word[WORD_W-1:WAY_NUM];

  // Per-way compare and victim tag of the chosen way
  always_comb begin
    evict_tag = '0;
    for (int w = 0; w < WAY_NUM; w++) begin
      tag_cmp_vect[w] = (set_tags[w] == tag_r);
      if (way_vect[w]) begin
        evict_tag = evict_tag | set_tags[w];
      end
    end
  end

  // Fill of the chosen way on a miss
  always_comb begin
    fill_val  = ld_val_vect;
    fill_tags = set_tags;
    for (int w = 0; w < WAY_NUM; w++) begin
      if (way_vect[w]) begin
        fill_val[w]  = 1'b1;
        fill_tags[w] = tag_r;
      end
    end
  end

  assign word_next = hit ? set_word : {fill_tags, fill_val};

  sram_dp #(
    .WIDTH (WORD_W),
    .DEPTH (SET_NUM)
  ) u_tag_mem (
    .clk        (clk),
    .read_en    (req),
    .read_addr  (idx),
    .read_data  (word_sram),
    // A hit leaves the set as it is
    .write_en   (clean_run | (req_r & ~hit)),
    .write_addr (clean_run ? clean_addr_r : idx_r),
    .write_data (clean_run ? '0 : word_next)
  );

endmodule

// File: lru/l1_lrum.sv
// L1 replacement state
// One used bit per way and set, with self-clean after reset,
// same-set bypass, hit detection and way choice

module l1_lrum #(
  parameter int WAY_NUM   = 4,
  parameter int SET_NUM   = 16,
  parameter int TAG_WIDTH = 8
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // Read stage
  input  logic                       req,
  input  logic [$clog2(SET_NUM)-1:0] idx,
  output logic                       ready,
  // Analyze stage
  input  logic [WAY_NUM-1:0]         ld_val_vect,
  input  logic [WAY_NUM-1:0]         tag_cmp_vect,
  output logic                       hit,
  output logic                       evict_val,
  output logic [WAY_NUM-1:0]         way_vect
);

  import l1_pkg::*;

  localparam int IDX_W = $clog2(SET_NUM);

  // Self-clean
  clean_state_e        clean_state_r;
  logic [IDX_W-1:0]    clean_addr_r;
  logic                clean_run;

  // Read stage registers
  logic                req_r;
  logic [IDX_W-1:0]    idx_r;
  logic                bypass_r;
  logic [WAY_NUM-1:0]  used_byp_r;

  // Analyze stage
  logic [WAY_NUM-1:0]  used_sram;
  logic [WAY_NUM-1:0]  used;
  logic [WAY_NUM-1:0]  hit_vect;
  logic [WAY_NUM-1:0]  alloc_vect;
  logic [WAY_NUM-1:0]  used_upd;
  logic [WAY_NUM-1:0]  used_next;

  // RAM write side
  logic                mem_wen;
  logic [IDX_W-1:0]    mem_waddr;
  logic [WAY_NUM-1:0]  mem_wdata;

  // Lowest set bit of a vector, zero for zero input
  function automatic logic [WAY_NUM-1:0] lowest_one(input logic [WAY_NUM-1:0] vec);
    logic found;
    found      = 1'b0;
    lowest_one = '0;
    for (int i = 0; i < WAY_NUM; i++) begin
      if (vec[i] && !found) begin
        lowest_one[i] = 1'b1;
        found         = 1'b1;
      end
    end
  endfunction

  // ------------------------------
  // Hardware clean
  // ------------------------------

  // One set per cycle, done after the last index
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clean_state_r <= CLEAN_RUN;
      clean_addr_r  <= '0;
    end else if (clean_state_r == CLEAN_RUN) begin
      clean_addr_r <= clean_addr_r + 1'b1;
      if (clean_addr_r == IDX_W'(SET_NUM - 1)) begin
        clean_state_r <= CLEAN_DONE;
      end
    end
  end

  assign clean_run = (clean_state_r == CLEAN_RUN);
  assign ready     = ~clean_run;

  // ------------------------------
  // Read stage
  // ------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_r    <= 1'b0;
      bypass_r <= 1'b0;
    end else begin
      req_r    <= req;
      // Same set as the one in analyze, RAM would return stale bits
      bypass_r <= req & req_r & (idx == idx_r);
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      idx_r <= idx;
    end
  end

  // Last written bits, for the back-to-back case
  always_ff @(posedge clk) begin
    if (req_r) begin
      used_byp_r <= used_next;
    end
  end

  // ------------------------------
  // Analyze stage
  // ------------------------------

  assign used       = bypass_r ? used_byp_r : used_sram;
  assign hit_vect   = ld_val_vect & tag_cmp_vect;
  assign hit        = req_r & (|hit_vect);
  assign evict_val  = req_r & ~(|hit_vect) & (&ld_val_vect);
  // Miss takes the lowest way with a clear used bit
  assign alloc_vect = lowest_one(~used);
  assign way_vect   = (|hit_vect) ? hit_vect : alloc_vect;

  // Set the chosen bit, restart the round when all are set
  assign used_upd   = used | way_vect;
  assign used_next  = (&used_upd) ? way_vect : used_upd;

  // Clean has the write port until it is done
  assign mem_wen    = clean_run | req_r;
  assign mem_waddr  = clean_run ? clean_addr_r : idx_r;
  assign mem_wdata  = clean_run ? '0 : used_next;

  sram_dp #(
    .WIDTH (WAY_NUM),
    .DEPTH (SET_NUM)
  ) u_used_mem (
    .clk        (clk),
    .read_en    (req),
    .read_addr  (idx),
    .read_data  (used_sram),
    .write_en   (mem_wen),
    .write_addr (mem_waddr),
    .write_data (mem_wdata)
  );

endmodule

// File: logic/sram_dp.sv
// Two-port synchronous RAM
// One write port, one read port with a registered output

module sram_dp #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  // Read port
  input  logic                     read_en,
  input  logic [$clog2(DEPTH)-1:0] read_addr,
  output logic [WIDTH-1:0]         read_data,
  // Write port
  input  logic                     write_en,
  input  logic [$clog2(DEPTH)-1:0] write_addr,
  input  logic [WIDTH-1:0]         write_data
);

  // Storage, no reset
  logic [WIDTH-1:0] mem [DEPTH];

  // ------------------------------
  // Write port
  // ------------------------------

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[write_addr] <= write_data;
    end
  end

  // ------------------------------
  // Read port
  // ------------------------------

  // Old data on a same-address write in the same edge
  // Users cover that with their own bypass
  always_ff @(posedge clk) begin
    if (read_en) begin
      read_data <= mem[read_addr];
    end
  end

endmodule

// File: common/l1_pkg.sv
// L1 directory shared package
// Self-clean state type and default cache geometry

package l1_pkg;

  // ------------------------------
  // Self-clean state
  // ------------------------------

  // One state bit per array
  // Run walks every set, done holds until reset
  typedef enum logic {
    CLEAN_RUN  = 1'b0,
    CLEAN_DONE = 1'b1
  } clean_state_e;

  // ------------------------------
  // Default geometry
  // ------------------------------

  // Ways per set
  // Any value of 2 or more works
  parameter int WAY_NUM_DEF   = 4;

  // Sets in the directory
  // Must be a power of two
  parameter int SET_NUM_DEF   = 16;

  // Stored tag bits per way
  parameter int TAG_WIDTH_DEF = 8;

  // Total storage per set, for reference
  // One valid bit plus one tag per way
  parameter int SET_BITS_DEF  = WAY_NUM_DEF * (TAG_WIDTH_DEF + 1);

endpackage
